// ==== hdl/ctrl_cfg_pkg.sv ====
// Configuration constants for the per-core controller.
// Holds widths, descriptor type codes, field positions and the
// status-channel address codes in both directions.
// Import it wherever one of these constants is needed.

package ctrl_cfg_pkg;

  // Widths
  localparam int dmem_addr_w   = 15;
  localparam int mem_addr_w    = 25;
  localparam int msg_addr_w    = 11;
  localparam int status_addr_w = 3;
  localparam int slot_count    = 16;
  // Slot numbers run 1..slot_count, 0 means no slot
  localparam int slot_w        = $clog2(slot_count + 1);
  localparam int tag_w         = 5;

  // Descriptor header fields
  localparam int desc_type_lsb = 60;
  localparam int slot_lsb      = 16;

  // Descriptor types that release a slot
  localparam logic [3:0] desc_type_send    = 4'd0;
  localparam logic [3:0] desc_type_drop    = 4'd1;
  localparam logic [3:0] desc_type_hdr     = 4'd2;
  // Descriptor types that carry a DRAM address beat
  localparam logic [3:0] desc_type_dram_rd = 4'd4;
  localparam logic [3:0] desc_type_dram_wr = 4'd5;

  // Output beat of the descriptor merger
  localparam logic beat_hdr  = 1'b0;
  localparam logic beat_dram = 1'b1;

  // Bit positions in the irq status word
  localparam int irq_flag_lsb  = 16;
  localparam int irq_tag_v_bit = 21;

  // Wrapper to core status addresses
  localparam logic [2:0] st_cfg      = 3'd0;
  localparam logic [2:0] st_timer_lo = 3'd1;
  localparam logic [2:0] st_timer_hi = 3'd2;
  localparam logic [2:0] st_irq      = 3'd3;
  localparam logic [2:0] st_debug_lo = 3'd4;
  localparam logic [2:0] st_debug_hi = 3'd5;
  localparam logic [2:0] st_items    = 3'd6;

  // Core to wrapper report addresses
  localparam logic [2:0] rp_idle     = 3'd0;
  localparam logic [2:0] rp_slot     = 3'd1;
  localparam logic [2:0] rp_debug_lo = 3'd2;
  localparam logic [2:0] rp_debug_hi = 3'd3;
  localparam logic [2:0] rp_tag_len  = 3'd4;

endpackage

// ==== hdl/ctrl_types_pkg.sv ====
// Packed structs exchanged between the controller blocks and with
// the core and the wrapper. Field order is MSB first.
// Import together with the config package in any block using them.

package ctrl_types_pkg;

  import ctrl_cfg_pkg::*;

  // Monitored data-memory write from the core
  typedef struct packed {
    logic                  en;
    logic                  wen;
    logic [3:0]            strb;
    logic [mem_addr_w-1:0] addr;
    logic [31:0]           wr_data;
  } dmem_mon_t;

  // Broadcast message toward the network
  typedef struct packed {
    logic [msg_addr_w-1:0] addr;
    logic [3:0]            strb;
    logic [31:0]           data;
  } bc_msg_t;

  // Outgoing descriptor, header plus DRAM address
  typedef struct packed {
    logic [63:0] hdr;
    logic [63:0] dram_addr;
  } desc_pair_t;

  // Addressed status word, same layout both ways
  typedef struct packed {
    logic [status_addr_w-1:0] addr;
    logic [31:0]              data;
  } status_word_t;

  typedef struct packed {
    logic [15:0] bc_region_size;
    logic [7:0]  core_id;
    logic [7:0]  max_slot_count;
  } wrapper_cfg_t;

  // Order matches the items status word
  typedef struct packed {
    logic [7:0] core_msg;
    logic [7:0] dram_req;
    logic [7:0] dram_send;
    logic [7:0] send_data;
  } item_counts_t;

  // Order matches irq word bits 20:16, also used for acks
  typedef struct packed {
    logic dupl_slot;
    logic inv_slot;
    logic inv_desc;
    logic poke;
    logic evict;
  } irq_t;

  // Reports from the core, sent back over the status channel
  typedef struct packed {
    logic [31:0] slot_wr_data;
    logic        slot_wr_valid;
    logic [15:0] sched_tag_len;
    logic        tag_len_wr_valid;
    logic [63:0] debug_out;
    logic        debug_out_l_valid;
    logic        debug_out_h_valid;
    logic [7:0]  core_errors;
    logic        ready_to_evict;
    logic [7:0]  mem_fifo_fulls;
  } core_report_t;

endpackage

// ==== hdl/bc_msg_tap.sv ====
// Broadcast tap on the core data-memory write port.
// Writes above the programmable start address become broadcast
// messages; while the sink is not ready the core memory is stalled.
// Purely combinational.

`timescale 1ns/10ps

module bc_msg_tap
  import ctrl_cfg_pkg::*, ctrl_types_pkg::*;
(
  input  dmem_mon_t              dmem_mon,
  input  logic [dmem_addr_w-1:0] bc_start_addr,
  output bc_msg_t                bc_msg,
  output logic                   bc_msg_valid,
  input  logic                   bc_msg_ready,
  output logic                   mem_bc_block
);

  logic wr_hit;
  logic above_start;

  // Only the low bits are compared, the region sits in local dmem
  assign above_start = dmem_mon.addr[dmem_addr_w-1:0] > bc_start_addr;

  // Enabled write into the broadcast region
  assign wr_hit = dmem_mon.en && dmem_mon.wen && above_start;

  ////////////////////
  // Message packing
  ////////////////////

  // Word address, byte offset dropped
  assign bc_msg.addr = dmem_mon.addr[msg_addr_w+1:2];
  assign bc_msg.strb = dmem_mon.strb;
  assign bc_msg.data = dmem_mon.wr_data;

  assign bc_msg_valid = wr_hit;

  // Hold the core memory while the write cannot leave
  assign mem_bc_block = bc_msg_valid && !bc_msg_ready;

endmodule

// ==== hdl/desc_ctrl.sv ====
// Descriptor merger and slot tracker.
// A core descriptor is sent as 64-bit words: DRAM read/write types
// take a header beat then an address beat, others a single beat.
// The slot bitmap marks slots taken from the input descriptor
// stream until a releasing descriptor for them leaves the core.

`timescale 1ns/10ps

module desc_ctrl
  import ctrl_cfg_pkg::*, ctrl_types_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  core_reset,
  input  desc_pair_t            core_desc,
  input  logic                  core_desc_valid,
  output logic                  core_desc_ready,
  output logic [63:0]           out_desc,
  output logic                  out_desc_2nd,
  output logic                  out_desc_valid,
  input  logic                  out_desc_ready,
  input  logic [63:0]           in_desc,
  input  logic                  in_desc_valid,
  input  logic                  in_desc_taken,
  output logic [slot_count:1]   slots_in_prog
);

  logic              beat_q;
  logic [3:0]        desc_type;
  logic              dram_desc;
  logic              release_desc;
  logic              out_fire;
  logic              hdr_of_dram;
  logic [slot_w-1:0] in_slot;
  logic [slot_w-1:0] out_slot;
  logic              slot_set;
  logic              slot_clr;
  logic [slot_count:1] slots_next;

  ////////////////////
  // Beat merger
  ////////////////////

  assign desc_type = core_desc.hdr[desc_type_lsb+:4];

  // Types needing a second word
  assign dram_desc = (desc_type == desc_type_dram_rd) ||
                     (desc_type == desc_type_dram_wr);

  // Types that finish with a slot
  assign release_desc = (desc_type == desc_type_send) ||
                        (desc_type == desc_type_drop) ||
                        (desc_type == desc_type_hdr);

  assign out_fire    = out_desc_valid && out_desc_ready;
  assign hdr_of_dram = (beat_q == beat_hdr) && dram_desc;

  assign out_desc_valid = core_desc_valid;
  assign out_desc_2nd   = (beat_q == beat_dram);
  assign out_desc       = out_desc_2nd ? core_desc.dram_addr : core_desc.hdr;

  // Core keeps its descriptor until the last beat goes out
  assign core_desc_ready = hdr_of_dram ? 1'b0 : out_desc_ready;

  always_ff @(posedge clk) begin
    if (!rst_n || core_reset) begin
      beat_q <= beat_hdr;
    end else if (out_fire) begin
      // Second beat only follows a DRAM header
      if (hdr_of_dram) begin
        beat_q <= beat_dram;
      end else begin
        beat_q <= beat_hdr;
      end
    end
  end

  ////////////////////
  // Slot tracking
  ////////////////////

  assign in_slot  = in_desc[slot_lsb+:slot_w];
  assign out_slot = core_desc.hdr[slot_lsb+:slot_w];

  assign slot_set = in_desc_valid && in_desc_taken;
  assign slot_clr = release_desc && out_fire;

  // Slot 0 and numbers past slot_count match no bit
  always_comb begin
    slots_next = slots_in_prog;
    for (int i = 1; i <= slot_count; i++) begin
      if (slot_set && (in_slot == slot_w'(i))) begin
        slots_next[i] = 1'b1;
      end
      // Release takes effect over a same-cycle take
      if (slot_clr && (out_slot == slot_w'(i))) begin
        slots_next[i] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || core_reset) begin
      slots_in_prog <= '0;
    end else begin
      slots_in_prog <= slots_next;
    end
  end

endmodule

// ==== hdl/status_rx.sv ====
// Receiver for the addressed status channel from the wrapper.
// Each word updates the register chosen by its address one cycle
// later: config, item counts, debug input, timer halves, or the
// interrupt flags with the received DRAM tag.
// Interrupts stay latched until acked.

`timescale 1ns/10ps

module status_rx
  import ctrl_cfg_pkg::*, ctrl_types_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             core_reset,
  input  status_word_t     wrapper_status,
  output wrapper_cfg_t     wrapper_cfg,
  output item_counts_t     item_counts,
  output logic [63:0]      debug_in,
  output logic [63:0]      timer,
  output logic [tag_w-1:0] recv_dram_tag,
  output logic             recv_dram_tag_v,
  output irq_t             irq,
  input  irq_t             irq_ack
);

  logic  [31:0] st_data;
  logic         irq_word;
  irq_t         irq_set;
  irq_t         irq_next;

  assign st_data  = wrapper_status.data;
  assign irq_word = (wrapper_status.addr == st_irq);

  ////////////////////
  // Interrupt latch
  ////////////////////

  // Flags in the irq word only raise, never lower
  assign irq_set = irq_word ? irq_t'(st_data[irq_flag_lsb+:5]) : '0;

  // Ack beats a set landing on the same cycle
  assign irq_next = irq_t'((irq | irq_set) & ~irq_ack);

  ////////////////////
  // Control state
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n || core_reset) begin
      timer           <= '0;
      irq             <= '0;
      recv_dram_tag_v <= 1'b0;
    end else begin
      irq <= irq_next;
      // Tag valid is a single-cycle strobe
      recv_dram_tag_v <= irq_word && st_data[irq_tag_v_bit];

      // Free-running, a load keeps the other half unincremented
      case (wrapper_status.addr)
        st_timer_lo: timer <= {timer[63:32], st_data};
        st_timer_hi: timer <= {st_data, timer[31:0]};
        default:     timer <= timer + 64'd1;
      endcase
    end
  end

  ////////////////////
  // Payload registers
  ////////////////////

  always_ff @(posedge clk) begin
    case (wrapper_status.addr)
      st_cfg: begin
        wrapper_cfg.bc_region_size <= st_data[15:0];
        wrapper_cfg.max_slot_count <= st_data[23:16];
        wrapper_cfg.core_id        <= st_data[31:24];
      end
      st_irq: begin
        recv_dram_tag <= st_data[tag_w-1:0];
      end
      st_debug_lo: begin
        debug_in[31:0] <= st_data;
      end
      st_debug_hi: begin
        debug_in[63:32] <= st_data;
      end
      st_items: begin
        // Field order of the struct follows the word
        item_counts <= item_counts_t'(st_data);
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== hdl/status_tx.sv ====
// Transmitter for the core side of the status channel.
// Picks one core report per cycle by fixed priority: slot write,
// tag length, debug low, debug high, then the idle status word.
// Combinational; the channel always accepts a slot write.

`timescale 1ns/10ps

module status_tx
  import ctrl_cfg_pkg::*, ctrl_types_pkg::*;
(
  input  core_report_t core_report,
  input  logic         core_reset,
  output status_word_t core_status,
  output logic         slot_wr_ready
);

  logic [31:0] idle_word;

  // Idle word: reset, evict readiness, FIFO fulls and errors
  assign idle_word = {14'd0,
                      core_reset,
                      core_report.ready_to_evict,
                      core_report.mem_fifo_fulls,
                      core_report.core_errors};

  ////////////////////
  // Priority select
  ////////////////////

  always_comb begin
    if (core_report.slot_wr_valid) begin
      core_status.addr = rp_slot;
      core_status.data = core_report.slot_wr_data;
    end else if (core_report.tag_len_wr_valid) begin
      core_status.addr = rp_tag_len;
      core_status.data = {16'd0, core_report.sched_tag_len};
    end else if (core_report.debug_out_l_valid) begin
      core_status.addr = rp_debug_lo;
      core_status.data = core_report.debug_out[31:0];
    end else if (core_report.debug_out_h_valid) begin
      core_status.addr = rp_debug_hi;
      core_status.data = core_report.debug_out[63:32];
    end else begin
      // Nothing to report, send core state
      core_status.addr = rp_idle;
      core_status.data = idle_word;
    end
  end

  // Slot writes have top priority so they never wait
  assign slot_wr_ready = 1'b1;

endmodule

// ==== hdl/core_ctrl.sv ====
// Per-core controller top level.
// Joins the broadcast tap, the descriptor merger with slot
// tracking, and both directions of the status channel between
// the packet core and its wrapper. Only wiring lives here.

`timescale 1ns/10ps

module core_ctrl
  import ctrl_cfg_pkg::*, ctrl_types_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   core_reset,
  // Broadcast messages
  input  dmem_mon_t              dmem_mon,
  input  logic [dmem_addr_w-1:0] bc_start_addr,
  output bc_msg_t                bc_msg,
  output logic                   bc_msg_valid,
  input  logic                   bc_msg_ready,
  output logic                   mem_bc_block,
  // Descriptors
  input  desc_pair_t             core_desc,
  input  logic                   core_desc_valid,
  output logic                   core_desc_ready,
  output logic [63:0]            out_desc,
  output logic                   out_desc_2nd,
  output logic                   out_desc_valid,
  input  logic                   out_desc_ready,
  input  logic [63:0]            in_desc,
  input  logic                   in_desc_valid,
  input  logic                   in_desc_taken,
  output logic [slot_count:1]    slots_in_prog,
  // Status from the wrapper
  input  status_word_t           wrapper_status,
  output wrapper_cfg_t           wrapper_cfg,
  output item_counts_t           item_counts,
  output logic [63:0]            debug_in,
  output logic [63:0]            timer,
  output logic [tag_w-1:0]       recv_dram_tag,
  output logic                   recv_dram_tag_v,
  output irq_t                   irq,
  input  irq_t                   irq_ack,
  // Status to the wrapper
  input  core_report_t           core_report,
  output status_word_t           core_status,
  output logic                   slot_wr_ready
);

  bc_msg_tap u_bc_msg_tap (
    .dmem_mon      (dmem_mon),
    .bc_start_addr (bc_start_addr),
    .bc_msg        (bc_msg),
    .bc_msg_valid  (bc_msg_valid),
    .bc_msg_ready  (bc_msg_ready),
    .mem_bc_block  (mem_bc_block)
  );

  desc_ctrl u_desc_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .core_reset      (core_reset),
    .core_desc       (core_desc),
    .core_desc_valid (core_desc_valid),
    .core_desc_ready (core_desc_ready),
    .out_desc        (out_desc),
    .out_desc_2nd    (out_desc_2nd),
    .out_desc_valid  (out_desc_valid),
    .out_desc_ready  (out_desc_ready),
    .in_desc         (in_desc),
    .in_desc_valid   (in_desc_valid),
    .in_desc_taken   (in_desc_taken),
    .slots_in_prog   (slots_in_prog)
  );

  status_rx u_status_rx (
    .clk             (clk),
    .rst_n           (rst_n),
    .core_reset      (core_reset),
    .wrapper_status  (wrapper_status),
    .wrapper_cfg     (wrapper_cfg),
    .item_counts     (item_counts),
    .debug_in        (debug_in),
    .timer           (timer),
    .recv_dram_tag   (recv_dram_tag),
    .recv_dram_tag_v (recv_dram_tag_v),
    .irq             (irq),
    .irq_ack         (irq_ack)
  );

  // Idle report carries the core reset state
  status_tx u_status_tx (
    .core_report   (core_report),
    .core_reset    (core_reset),
    .core_status   (core_status),
    .slot_wr_ready (slot_wr_ready)
  );

endmodule

// ==== tests/core_ctrl_asserts.sv ====
// Concurrent checks for the descriptor merger and the status receiver.
// One module is bound into both blocks; the inputs that a block lacks
// are tied low in its bind, which leaves those checks idle there.

`timescale 1ns/10ps

module core_ctrl_asserts
  import ctrl_cfg_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       core_reset,
  input logic [3:0] desc_type,
  input logic       core_desc_ready,
  input logic       out_desc_2nd,
  input logic       out_desc_valid,
  input logic       out_desc_ready,
  input logic       tag_v
);

  logic dram_type;

  // DRAM read or write descriptor, needs the address beat
  assign dram_type = (desc_type == desc_type_dram_rd) ||
                     (desc_type == desc_type_dram_wr);

  // Accepted DRAM header keeps the core waiting and leads to the address beat
  hdr_beat_holds_core: assert property (
    @(posedge clk) disable iff (!rst_n || core_reset)
    (dram_type && !out_desc_2nd && out_desc_valid && out_desc_ready) |=>
      (out_desc_2nd && !$past(core_desc_ready))
  ) else $error("DRAM header beat released the core or skipped its address beat");

  // Address beat ends with its transfer
  second_beat_once: assert property (
    @(posedge clk) disable iff (!rst_n || core_reset)
    (out_desc_2nd && out_desc_valid && out_desc_ready) |=> !out_desc_2nd
  ) else $error("out_desc_2nd still high after an accepted address beat");

  // Tag valid is a one-cycle strobe
  tag_v_single: assert property (
    @(posedge clk) disable iff (!rst_n || core_reset)
    tag_v |=> !tag_v
  ) else $error("recv_dram_tag_v high on two cycles in a row");

endmodule

bind desc_ctrl core_ctrl_asserts u_desc_asserts (
  .clk             (clk),
  .rst_n           (rst_n),
  .core_reset      (core_reset),
  .desc_type       (core_desc.hdr[63:60]),
  .core_desc_ready (core_desc_ready),
  .out_desc_2nd    (out_desc_2nd),
  .out_desc_valid  (out_desc_valid),
  .out_desc_ready  (out_desc_ready),
  .tag_v           (1'b0)
);

bind status_rx core_ctrl_asserts u_rx_asserts (
  .clk             (clk),
  .rst_n           (rst_n),
  .core_reset      (core_reset),
  .desc_type       (4'd0),
  .core_desc_ready (1'b0),
  .out_desc_2nd    (1'b0),
  .out_desc_valid  (1'b0),
  .out_desc_ready  (1'b0),
  .tag_v           (recv_dram_tag_v)
);

// ==== tests/tb_core_ctrl.sv ====
// Testbench for the per-core controller top level.
// Drives random broadcast writes, descriptors, status words and core
// reports each cycle, keeps a reference model of the registered state
// and compares every DUT output once per cycle at the falling edge.

`timescale 1ns/10ps

module tb_core_ctrl
  import ctrl_cfg_pkg::*, ctrl_types_pkg::*;
();

  localparam int reset_cycles   = 4;
  localparam int run_cycles     = 500;
  localparam int timeout_cycles = reset_cycles + run_cycles + 100;

  logic                   clk;
  logic                   rst_n;
  logic                   core_reset;
  dmem_mon_t              dmem_mon;
  logic [dmem_addr_w-1:0] bc_start_addr;
  bc_msg_t                bc_msg;
  logic                   bc_msg_valid;
  logic                   bc_msg_ready;
  logic                   mem_bc_block;
  desc_pair_t             core_desc;
  logic                   core_desc_valid;
  logic                   core_desc_ready;
  logic [63:0]            out_desc;
  logic                   out_desc_2nd;
  logic                   out_desc_valid;
  logic                   out_desc_ready;
  logic [63:0]            in_desc;
  logic                   in_desc_valid;
  logic                   in_desc_taken;
  logic [slot_count:1]    slots_in_prog;
  status_word_t           wrapper_status;
  wrapper_cfg_t           wrapper_cfg;
  item_counts_t           item_counts;
  logic [63:0]            debug_in;
  logic [63:0]            timer;
  logic [tag_w-1:0]       recv_dram_tag;
  logic                   recv_dram_tag_v;
  irq_t                   irq;
  irq_t                   irq_ack;
  core_report_t           core_report;
  status_word_t           core_status;
  logic                   slot_wr_ready;

  // Reference model state
  logic                   model_beat;
  logic [slot_count:1]    model_slots;
  wrapper_cfg_t           model_cfg;
  item_counts_t           model_items;
  logic [63:0]            model_debug;
  logic [63:0]            model_timer;
  logic [tag_w-1:0]       model_tag;
  logic                   model_tag_v;
  logic [4:0]             model_irq;
  // Payload registers start unknown and are compared once written
  logic cfg_seen    = 1'b0;
  logic items_seen  = 1'b0;
  logic dbg_lo_seen = 1'b0;
  logic dbg_hi_seen = 1'b0;
  logic tag_seen    = 1'b0;
  // Core descriptor fully accepted on the last edge
  logic desc_done   = 1'b0;

  integer seed           = 52;
  int     errors         = 0;
  int     cycles_checked = 0;
  int     cycle_count    = 0;

  core_ctrl DUT (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  ////////////////////
  // Reference functions
  ////////////////////

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic is_dram(logic [63:0] hdr);
    return (hdr[63:60] == desc_type_dram_rd) || (hdr[63:60] == desc_type_dram_wr);
  endfunction

  function automatic logic is_release(logic [63:0] hdr);
    return (hdr[63:60] == desc_type_send) || (hdr[63:60] == desc_type_drop) ||
           (hdr[63:60] == desc_type_hdr);
  endfunction

  function automatic logic exp_bc_valid(dmem_mon_t m, logic [dmem_addr_w-1:0] start);
    return m.en && m.wen && (m.addr[dmem_addr_w-1:0] > start);
  endfunction

  function automatic bc_msg_t exp_bc_msg(dmem_mon_t m);
    bc_msg_t msg;
    // Word address starts at bit 2
    msg.addr = m.addr[msg_addr_w+1:2];
    msg.strb = m.strb;
    msg.data = m.wr_data;
    return msg;
  endfunction

  function automatic logic [63:0] exp_out_word(logic beat, desc_pair_t d);
    return beat ? d.dram_addr : d.hdr;
  endfunction

  function automatic logic exp_desc_ready(logic beat, logic [63:0] hdr, logic rdy);
    // DRAM header beat holds the core
    return (!beat && is_dram(hdr)) ? 1'b0 : rdy;
  endfunction

  function automatic logic [slot_count:1] next_slots(logic [slot_count:1] cur,
      logic set_en, logic [slot_w-1:0] set_slot, logic clr_en, logic [slot_w-1:0] clr_slot);
    logic [slot_count:1] nxt;
    nxt = cur;
    if (set_en && (set_slot != '0) && (set_slot <= slot_w'(slot_count))) begin
      nxt[set_slot] = 1'b1;
    end
    // Release applied last so it wins on the same slot
    if (clr_en && (clr_slot != '0) && (clr_slot <= slot_w'(slot_count))) begin
      nxt[clr_slot] = 1'b0;
    end
    return nxt;
  endfunction

  function automatic logic [63:0] next_timer(logic [63:0] t, status_word_t w);
    if (w.addr == st_timer_lo) begin
      return {t[63:32], w.data};
    end
    if (w.addr == st_timer_hi) begin
      return {w.data, t[31:0]};
    end
    return t + 64'd1;
  endfunction

  function automatic status_word_t exp_core_status(core_report_t r, logic rst);
    status_word_t w;
    w.addr = rp_idle;
    w.data = {14'd0, rst, r.ready_to_evict, r.mem_fifo_fulls, r.core_errors};
    // Lowest priority first so each later one overrides
    if (r.debug_out_h_valid) begin
      w.addr = rp_debug_hi;
      w.data = r.debug_out[63:32];
    end
    if (r.debug_out_l_valid) begin
      w.addr = rp_debug_lo;
      w.data = r.debug_out[31:0];
    end
    if (r.tag_len_wr_valid) begin
      w.addr = rp_tag_len;
      w.data = {16'd0, r.sched_tag_len};
    end
    if (r.slot_wr_valid) begin
      w.addr = rp_slot;
      w.data = r.slot_wr_data;
    end
    return w;
  endfunction

  ////////////////////
  // Model update
  ////////////////////

  always @(posedge clk) begin : model_update
    logic out_fire;
    logic in_fire;
    out_fire  = core_desc_valid && out_desc_ready;
    in_fire   = in_desc_valid && in_desc_taken;
    desc_done = core_desc_valid && exp_desc_ready(model_beat, core_desc.hdr, out_desc_ready);
    // Payload fields load regardless of reset
    case (wrapper_status.addr)
      st_cfg: begin
        model_cfg.bc_region_size = wrapper_status.data[15:0];
        model_cfg.max_slot_count = wrapper_status.data[23:16];
        model_cfg.core_id        = wrapper_status.data[31:24];
        cfg_seen = 1'b1;
      end
      st_irq: begin
        model_tag = wrapper_status.data[tag_w-1:0];
        tag_seen  = 1'b1;
      end
      st_debug_lo: begin
        model_debug[31:0] = wrapper_status.data;
        dbg_lo_seen = 1'b1;
      end
      st_debug_hi: begin
        model_debug[63:32] = wrapper_status.data;
        dbg_hi_seen = 1'b1;
      end
      st_items: begin
        model_items.core_msg  = wrapper_status.data[31:24];
        model_items.dram_req  = wrapper_status.data[23:16];
        model_items.dram_send = wrapper_status.data[15:8];
        model_items.send_data = wrapper_status.data[7:0];
        items_seen = 1'b1;
      end
      default: begin
      end
    endcase
    if (!rst_n || core_reset) begin
      model_beat  = 1'b0;
      model_slots = '0;
      model_timer = '0;
      model_irq   = '0;
      model_tag_v = 1'b0;
    end else begin
      model_slots = next_slots(model_slots, in_fire, in_desc[16+:slot_w],
                               out_fire && is_release(core_desc.hdr),
                               core_desc.hdr[16+:slot_w]);
      if (out_fire) begin
        model_beat = !model_beat && is_dram(core_desc.hdr);
      end
      if (wrapper_status.addr == st_irq) begin
        model_irq   = (model_irq | wrapper_status.data[20:16]) & ~irq_ack;
        model_tag_v = wrapper_status.data[21];
      end else begin
        model_irq   = model_irq & ~irq_ack;
        model_tag_v = 1'b0;
      end
      model_timer = next_timer(model_timer, wrapper_status);
    end
  end

  ////////////////////
  // Comparison
  ////////////////////

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
    $display("mismatch at %0d ns: %s expected %h got %h", $time, name, exp, got);
    errors++;
  endtask

  always @(negedge clk) begin : compare
    logic         exp_valid;
    status_word_t exp_status;
    if (rst_n) begin
      cycles_checked++;
      exp_valid  = exp_bc_valid(dmem_mon, bc_start_addr);
      exp_status = exp_core_status(core_report, core_reset);
      if (bc_msg_valid !== exp_valid)
        report_mismatch("bc_msg_valid", 64'(exp_valid), 64'(bc_msg_valid));
      if (exp_valid && (bc_msg !== exp_bc_msg(dmem_mon)))
        report_mismatch("bc_msg", 64'(exp_bc_msg(dmem_mon)), 64'(bc_msg));
      if (mem_bc_block !== (exp_valid && !bc_msg_ready))
        report_mismatch("mem_bc_block", 64'(exp_valid && !bc_msg_ready), 64'(mem_bc_block));
      if (out_desc_valid !== core_desc_valid)
        report_mismatch("out_desc_valid", 64'(core_desc_valid), 64'(out_desc_valid));
      if (out_desc_2nd !== model_beat)
        report_mismatch("out_desc_2nd", 64'(model_beat), 64'(out_desc_2nd));
      if (out_desc !== exp_out_word(model_beat, core_desc))
        report_mismatch("out_desc", exp_out_word(model_beat, core_desc), out_desc);
      if (core_desc_ready !== exp_desc_ready(model_beat, core_desc.hdr, out_desc_ready))
        report_mismatch("core_desc_ready",
                        64'(exp_desc_ready(model_beat, core_desc.hdr, out_desc_ready)),
                        64'(core_desc_ready));
      if (slots_in_prog !== model_slots)
        report_mismatch("slots_in_prog", 64'(model_slots), 64'(slots_in_prog));
      if (cfg_seen && (wrapper_cfg !== model_cfg))
        report_mismatch("wrapper_cfg", 64'(model_cfg), 64'(wrapper_cfg));
      if (items_seen && (item_counts !== model_items))
        report_mismatch("item_counts", 64'(model_items), 64'(item_counts));
      if (dbg_lo_seen && (debug_in[31:0] !== model_debug[31:0]))
        report_mismatch("debug_in_lo", 64'(model_debug[31:0]), 64'(debug_in[31:0]));
      if (dbg_hi_seen && (debug_in[63:32] !== model_debug[63:32]))
        report_mismatch("debug_in_hi", 64'(model_debug[63:32]), 64'(debug_in[63:32]));
      if (timer !== model_timer)
        report_mismatch("timer", model_timer, timer);
      if (tag_seen && (recv_dram_tag !== model_tag))
        report_mismatch("recv_dram_tag", 64'(model_tag), 64'(recv_dram_tag));
      if (recv_dram_tag_v !== model_tag_v)
        report_mismatch("recv_dram_tag_v", 64'(model_tag_v), 64'(recv_dram_tag_v));
      if (irq !== model_irq)
        report_mismatch("irq", 64'(model_irq), 64'(irq));
      if (core_status !== exp_status)
        report_mismatch("core_status", 64'(exp_status), 64'(core_status));
      if (slot_wr_ready !== 1'b1)
        report_mismatch("slot_wr_ready", 64'(1'b1), 64'(slot_wr_ready));
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic drive_cycle(input int n);
    logic [31:0] r;
    logic [31:0] s;
    logic        last_tag_v;
    last_tag_v = (wrapper_status.addr == st_irq) && wrapper_status.data[21];
    r = rand_word();
    s = rand_word();
    // New broadcast region now and then
    if ((n % 64) == 0) begin
      bc_start_addr = s[dmem_addr_w-1:0];
      s = rand_word();
    end
    // Writes land within a few words of the start address
    dmem_mon.en      = r[0];
    dmem_mon.wen     = r[1];
    dmem_mon.strb    = r[7:4];
    dmem_mon.addr    = {r[17:8], bc_start_addr + 15'(s % 9) - 15'd4};
    dmem_mon.wr_data = rand_word();
    bc_msg_ready     = r[2];
    out_desc_ready   = r[3];
    // Hold a descriptor until the core side accepts it
    if (!core_desc_valid || desc_done) begin
      core_desc.hdr            = {rand_word(), rand_word()};
      core_desc.hdr[63:60]     = 4'(rand_word() % 8);
      core_desc.hdr[20:16]     = 5'(rand_word() % 18);
      core_desc.dram_addr      = {rand_word(), rand_word()};
      core_desc_valid          = (r[19:18] != 2'b00);
    end
    in_desc          = {rand_word(), rand_word()};
    in_desc[20:16]   = 5'(rand_word() % 18);
    in_desc_valid    = r[20];
    in_desc_taken    = r[21];
    r = rand_word();
    s = rand_word();
    wrapper_status.addr = r[2:0];
    // The wrapper never sends two DRAM tags back to back
    if (last_tag_v) begin
      s[21] = 1'b0;
    end
    wrapper_status.data = s;
    // Sparse acks so flags stay up for a while
    irq_ack = irq_t'(r[12:8] & r[20:16]);
    core_report.slot_wr_data      = rand_word();
    core_report.sched_tag_len     = s[31:16];
    core_report.debug_out         = {rand_word(), rand_word()};
    s = rand_word();
    core_report.slot_wr_valid     = s[0] & s[1];
    core_report.tag_len_wr_valid  = s[2] & s[3];
    core_report.debug_out_l_valid = s[4] & s[5];
    core_report.debug_out_h_valid = s[6] & s[7];
    core_report.core_errors       = s[15:8];
    core_report.mem_fifo_fulls    = s[23:16];
    core_report.ready_to_evict    = s[24];
    // Short core reset pulse in the middle of the run
    core_reset = (n == 250) || (n == 251);
  endtask

  initial begin : stimulus
    rst_n           = 1'b0;
    core_reset      = 1'b0;
    dmem_mon        = '0;
    bc_start_addr   = '0;
    bc_msg_ready    = 1'b0;
    core_desc       = '0;
    core_desc_valid = 1'b0;
    out_desc_ready  = 1'b0;
    in_desc         = '0;
    in_desc_valid   = 1'b0;
    in_desc_taken   = 1'b0;
    // Unused address keeps payload registers still
    wrapper_status  = '{addr: 3'd7, data: 32'd0};
    irq_ack         = '0;
    core_report     = '0;
    repeat (reset_cycles) @(posedge clk);
    #5;
    rst_n = 1'b1;
    for (int n = 0; n < run_cycles; n++) begin
      drive_cycle(n);
      @(posedge clk);
      #5;
    end
    $display("Cycles checked: %0d, errors: %0d", cycles_checked, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog on the cycle count
  initial begin : watchdog
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not end within %0d cycles", timeout_cycles);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== all.f ====
hdl/ctrl_cfg_pkg.sv
hdl/ctrl_types_pkg.sv
hdl/bc_msg_tap.sv
hdl/desc_ctrl.sv
hdl/status_rx.sv
hdl/status_tx.sv
hdl/core_ctrl.sv
tests/core_ctrl_asserts.sv
tests/tb_core_ctrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the core controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_core_ctrl -f all.f -o sim_core_ctrl
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_core_ctrl)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "No errors" <<< "$sim_out"; then
  exit 0
fi
exit 1
